// File: rtl/mod_pkg.sv
`default_nettype none

package mod_pkg;

  localparam int MEM_READ_LATENCY = 2;   // Sample RAM, read reg plus output reg
  localparam int ADDR_CALC_LATENCY = 2;  // Subtract delay, then wrap
  localparam int SCALE_LATENCY = 4;      // Multiply, reciprocal, shift, output

  // Cycles from the first input entry to the first output entry
  localparam int MULT_LATENCY = ADDR_CALC_LATENCY + MEM_READ_LATENCY + SCALE_LATENCY;

  localparam int MOD_ADDR_WIDTH = 16;    // Index, cycle and delay
  localparam int MOD_DATA_WIDTH = 8;     // One modulation sample

  typedef enum logic {
    GEN_IDLE,
    GEN_STREAM
  } gen_state_t;

  typedef enum logic {
    MULT_WAIT,
    MULT_RUN
  } mult_state_t;

endpackage

`default_nettype wire

// File: rtl/drive_table_gen.sv
`default_nettype none

module drive_table_gen #(
  parameter int WIDTH = 13,
  parameter int DEPTH = 249
) (
  input  var logic                                CLK,
  input  var logic                                reset,
  input  var logic                                frame_start,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  cycle_m,
  input  var logic                                tbl_we,
  input  var logic [$clog2(DEPTH)-1:0]            tbl_addr,
  input  var logic [WIDTH-1:0]                    tbl_duty,
  input  var logic [WIDTH-1:0]                    tbl_phase,
  output logic                                    din_valid,
  output logic [WIDTH-1:0]                        duty_stream,
  output logic [WIDTH-1:0]                        phase_stream,
  output logic [mod_pkg::MOD_ADDR_WIDTH-1:0]      mod_idx,
  output logic                                    busy
);

  import mod_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam int DRAIN_W = $clog2(MULT_LATENCY + 1);

  logic [WIDTH-1:0] duty_tbl [DEPTH];
  logic [WIDTH-1:0] phase_tbl [DEPTH];

  gen_state_t state;
  logic [AW:0] rd_cnt;                  // Next entry to present
  logic [DRAIN_W-1:0] drain_cnt;        // Cycles left until the multiplier is empty

  always_ff @(posedge CLK) begin
    if (tbl_we && (tbl_addr < DEPTH)) begin
      duty_tbl[tbl_addr] <= tbl_duty;
      phase_tbl[tbl_addr] <= tbl_phase;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= GEN_IDLE;
      din_valid <= 1'b0;
      busy <= 1'b0;
      rd_cnt <= '0;
      drain_cnt <= '0;
      mod_idx <= '0;
    end else begin
      case (state)
        GEN_IDLE: begin
          if (busy) begin
            drain_cnt <= drain_cnt - 1'b1;
            if (drain_cnt == DRAIN_W'(1)) begin
              busy <= 1'b0;
            end
          end else if (frame_start) begin   // Strobes during busy are dropped
            state <= GEN_STREAM;
            din_valid <= 1'b1;
            busy <= 1'b1;
            rd_cnt <= (AW + 1)'(1);
          end
        end
        GEN_STREAM: begin
          if (rd_cnt == (AW + 1)'(DEPTH)) begin
            state <= GEN_IDLE;
            din_valid <= 1'b0;
            drain_cnt <= DRAIN_W'(MULT_LATENCY);
            mod_idx <= (mod_idx >= cycle_m) ? '0 : mod_idx + 1'b1;
          end else begin
            rd_cnt <= rd_cnt + 1'b1;
          end
        end
        default: begin
          state <= GEN_IDLE;
        end
      endcase
    end
  end

  // Entry 0 waits on the outputs so it is ready with the first valid
  always_ff @(posedge CLK) begin
    if (state == GEN_IDLE) begin
      duty_stream <= duty_tbl[0];
      phase_stream <= phase_tbl[0];
    end else if (rd_cnt < (AW + 1)'(DEPTH)) begin
      duty_stream <= duty_tbl[rd_cnt[AW-1:0]];
      phase_stream <= phase_tbl[rd_cnt[AW-1:0]];
    end
  end

endmodule

`default_nettype wire

// File: rtl/mod_sample_mem.sv
`default_nettype none

module mod_sample_mem #(
  parameter int MOD_SIZE = 256
) (
  input  var logic                                CLK,
  input  var logic                                mod_we,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  mod_waddr,
  input  var logic [mod_pkg::MOD_DATA_WIDTH-1:0]  mod_wdata,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  mod_raddr,
  output logic [mod_pkg::MOD_DATA_WIDTH-1:0]      mod_rdata
);

  import mod_pkg::*;

  localparam int AW = $clog2(MOD_SIZE);

  logic [MOD_DATA_WIDTH-1:0] mem [MOD_SIZE];
  logic [MOD_DATA_WIDTH-1:0] rd_q;      // Array read register

  always_ff @(posedge CLK) begin
    if (mod_we && (mod_waddr < MOD_SIZE)) begin
      mem[mod_waddr[AW-1:0]] <= mod_wdata;
    end
  end

  // Read first, then the output register, as in block RAM
  always_ff @(posedge CLK) begin
    rd_q <= mem[mod_raddr[AW-1:0]];
    mod_rdata <= rd_q;
  end

endmodule

`default_nettype wire

// File: rtl/modulation_multiplier.sv
`default_nettype none

module modulation_multiplier #(
  parameter int WIDTH = 13,
  parameter int DEPTH = 249
) (
  input  var logic                                CLK,
  input  var logic                                reset,
  input  var logic                                din_valid,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  mod_idx,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  cycle_m,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  delay_m,
  input  var logic [mod_pkg::MOD_DATA_WIDTH-1:0]  mod_rdata,
  input  var logic [WIDTH-1:0]                    duty_in,
  input  var logic [WIDTH-1:0]                    phase_in,
  output logic [mod_pkg::MOD_ADDR_WIDTH-1:0]      mod_raddr,
  output logic [WIDTH-1:0]                        duty_out,
  output logic [WIDTH-1:0]                        phase_out,
  output logic                                    dout_valid
);

  import mod_pkg::*;

  localparam int CNT_W = $clog2(DEPTH);
  localparam int SEQ_W = $clog2(MULT_LATENCY);
  localparam int OUT_START = MULT_LATENCY - 1;
  localparam int DUTY_DLY = ADDR_CALC_LATENCY + MEM_READ_LATENCY;

  // floor(x / 255) as (x * m) >> s, exact for every product of duty and sample
  localparam int PROD_W = WIDTH + MOD_DATA_WIDTH;
  localparam int DIVISOR = 2 ** MOD_DATA_WIDTH - 1;
  localparam int RECIP_SHIFT = PROD_W + MOD_DATA_WIDTH;
  localparam int RECIP_W = PROD_W + 1;
  localparam longint unsigned RECIP_FULL =
    ((64'd1 << RECIP_SHIFT) + DIVISOR - 1) / DIVISOR;
  localparam logic [RECIP_W-1:0] RECIP = RECIP_W'(RECIP_FULL);

  mult_state_t state;
  logic [SEQ_W-1:0] seq_cnt;            // Cycles since the first input, saturating
  logic [CNT_W-1:0] wr_cnt;
  logic [CNT_W-1:0] out_cnt;

  logic [MOD_ADDR_WIDTH+1:0] idx_diff;  // Signed index minus delay
  logic [MOD_ADDR_WIDTH:0] cycle_p1;
  logic [MOD_ADDR_WIDTH+1:0] addr_wrapped;

  logic [WIDTH-1:0] duty_dly [DUTY_DLY];
  logic [WIDTH-1:0] phase_buf [DEPTH];
  logic [PROD_W-1:0] prod;
  logic [PROD_W+RECIP_W-1:0] recip_prod;
  logic [WIDTH-1:0] quo;

  assign addr_wrapped = idx_diff[MOD_ADDR_WIDTH+1] ? idx_diff + {1'b0, cycle_p1} : idx_diff;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= MULT_WAIT;
      dout_valid <= 1'b0;
      seq_cnt <= '0;
      wr_cnt <= '0;
      out_cnt <= '0;
      mod_raddr <= '0;
    end else begin
      if (din_valid) begin
        wr_cnt <= (wr_cnt == CNT_W'(DEPTH - 1)) ? '0 : wr_cnt + 1'b1;
      end
      case (state)
        MULT_WAIT: begin
          dout_valid <= 1'b0;
          if (din_valid) begin
            state <= MULT_RUN;
            seq_cnt <= SEQ_W'(1);
            out_cnt <= '0;
          end
        end
        MULT_RUN: begin
          if (seq_cnt == SEQ_W'(ADDR_CALC_LATENCY - 1)) begin
            mod_raddr <= addr_wrapped[MOD_ADDR_WIDTH-1:0];   // Held for the frame
          end
          if (seq_cnt != SEQ_W'(OUT_START)) begin
            seq_cnt <= seq_cnt + 1'b1;
          end else begin
            dout_valid <= 1'b1;
            if (out_cnt == CNT_W'(DEPTH - 1)) begin
              out_cnt <= '0;
              state <= MULT_WAIT;
            end else begin
              out_cnt <= out_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= MULT_WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == MULT_WAIT) && din_valid) begin
      idx_diff <= {2'b00, mod_idx} - {2'b00, delay_m};
      cycle_p1 <= {1'b0, cycle_m} + 1'b1;
    end
    if (din_valid) begin
      phase_buf[wr_cnt] <= phase_in;
    end
  end

  // Duty waits here until the sample for the frame is on mod_rdata
  always_ff @(posedge CLK) begin
    duty_dly[0] <= duty_in;
    for (int i = 1; i < DUTY_DLY; i++) begin
      duty_dly[i] <= duty_dly[i-1];
    end
  end

  always_ff @(posedge CLK) begin
    prod <= duty_dly[DUTY_DLY-1] * mod_rdata;
    recip_prod <= prod * RECIP;
    quo <= recip_prod[RECIP_SHIFT +: WIDTH];
    if ((state == MULT_RUN) && (seq_cnt == SEQ_W'(OUT_START))) begin
      duty_out <= quo;
      phase_out <= phase_buf[out_cnt];
    end
  end

endmodule

`default_nettype wire

// File: rtl/modulation_top.sv
`default_nettype none

module modulation_top #(
  parameter int WIDTH = 13,
  parameter int DEPTH = 249,
  parameter int MOD_SIZE = 256
) (
  input  var logic                                CLK,
  input  var logic                                reset,
  input  var logic                                frame_start,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  cycle_m,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  delay_m,
  input  var logic                                tbl_we,
  input  var logic [$clog2(DEPTH)-1:0]            tbl_addr,
  input  var logic [WIDTH-1:0]                    tbl_duty,
  input  var logic [WIDTH-1:0]                    tbl_phase,
  input  var logic                                mod_we,
  input  var logic [mod_pkg::MOD_ADDR_WIDTH-1:0]  mod_waddr,
  input  var logic [mod_pkg::MOD_DATA_WIDTH-1:0]  mod_wdata,
  output logic                                    dout_valid,
  output logic [WIDTH-1:0]                        duty_out,
  output logic [WIDTH-1:0]                        phase_out,
  output logic                                    busy
);

  import mod_pkg::*;

  logic din_valid;
  logic [WIDTH-1:0] duty_stream;
  logic [WIDTH-1:0] phase_stream;
  logic [MOD_ADDR_WIDTH-1:0] mod_idx;
  logic [MOD_ADDR_WIDTH-1:0] mod_raddr;
  logic [MOD_DATA_WIDTH-1:0] mod_rdata;

  drive_table_gen #(
    .WIDTH(WIDTH),
    .DEPTH(DEPTH)
  ) u_gen (
    .CLK         (CLK),
    .reset       (reset),
    .frame_start (frame_start),
    .cycle_m     (cycle_m),
    .tbl_we      (tbl_we),
    .tbl_addr    (tbl_addr),
    .tbl_duty    (tbl_duty),
    .tbl_phase   (tbl_phase),
    .din_valid   (din_valid),
    .duty_stream (duty_stream),
    .phase_stream(phase_stream),
    .mod_idx     (mod_idx),
    .busy        (busy)
  );

  mod_sample_mem #(
    .MOD_SIZE(MOD_SIZE)
  ) u_mem (
    .CLK      (CLK),
    .mod_we   (mod_we),
    .mod_waddr(mod_waddr),
    .mod_wdata(mod_wdata),
    .mod_raddr(mod_raddr),
    .mod_rdata(mod_rdata)
  );

  modulation_multiplier #(
    .WIDTH(WIDTH),
    .DEPTH(DEPTH)
  ) u_mult (
    .CLK       (CLK),
    .reset     (reset),
    .din_valid (din_valid),
    .mod_idx   (mod_idx),
    .cycle_m   (cycle_m),
    .delay_m   (delay_m),
    .mod_rdata (mod_rdata),
    .duty_in   (duty_stream),
    .phase_in  (phase_stream),
    .mod_raddr (mod_raddr),
    .duty_out  (duty_out),
    .phase_out (phase_out),
    .dout_valid(dout_valid)
  );

endmodule

`default_nettype wire

// File: verification/tb_modulation_checks.sv
`default_nettype none

module tb_modulation_checks #(
  parameter int WIDTH = 13,
  parameter int DEPTH = 16
) (
  input  var logic             CLK,
  input  var logic             reset,
  input  var logic             frame_start,
  input  var logic             busy,
  input  var logic             dout_valid,
  input  var logic [WIDTH-1:0] duty_out,
  input  var logic [WIDTH-1:0] phase_out,
  output int                   error_count,
  output int                   check_count,
  output int                   out_count
);

  timeunit 1ns;
  timeprecision 100ps;

  import mod_pkg::*;

  localparam int FIRST_OUT = 1 + MULT_LATENCY;   // Strobe to first output

  string test_name = "none";
  int exp_duty [$];
  int exp_phase [$];
  int errors = 0;
  int checks = 0;
  int outs = 0;
  int run_len = 0;                               // Outputs seen in the current run
  int want_duty;
  int want_phase;
  logic start_ok;

  assign error_count = errors;
  assign check_count = checks;
  assign out_count = outs;
  assign start_ok = frame_start && !busy;        // Strobe taken only when idle

  task automatic set_test(input string name);
    test_name = name;
  endtask

  function automatic int scaled_duty(input int duty, input int sample);
    return (duty * sample) / 255;
  endfunction

  task automatic push_expect(input int duty, input int phase, input int sample);
    exp_duty.push_back(scaled_duty(duty, sample));
    exp_phase.push_back(phase);
  endtask

  function automatic int pending_count();
    return exp_duty.size();
  endfunction

  task automatic note_failure(input string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  assert property (@(posedge CLK) disable iff (reset)
      start_ok |-> ##(FIRST_OUT - 1) !dout_valid ##1 dout_valid)
    else note_failure("first output did not follow the strobe by 9 cycles");

  assert property (@(posedge CLK) disable iff (reset) dout_valid |-> busy)
    else note_failure("output valid while busy was low");

  assert property (@(posedge CLK) disable iff (reset) $fell(busy) == $fell(dout_valid))
    else note_failure("busy did not fall right after the last output");

  // Outputs settle after the rising edge
  always @(negedge CLK) begin
    if (reset) begin
      run_len = 0;
    end else if (dout_valid) begin
      outs++;
      if (exp_duty.size() == 0) begin
        note_failure("output arrived with no expected entry");
      end else begin
        want_duty = exp_duty.pop_front();
        want_phase = exp_phase.pop_front();
        checks += 2;
        assert (int'(duty_out) == want_duty) else begin
          errors++;
          $display("CHECK FAILED %s: duty[%0d] expected %0d, actual %0d",
                   test_name, run_len, want_duty, duty_out);
        end
        assert (int'(phase_out) == want_phase) else begin
          errors++;
          $display("CHECK FAILED %s: phase[%0d] expected %0d, actual %0d",
                   test_name, run_len, want_phase, phase_out);
        end
      end
      run_len++;
    end else if (run_len != 0) begin
      checks++;
      assert (run_len == DEPTH) else begin
        errors++;
        $display("CHECK FAILED %s: output run length expected %0d, actual %0d",
                 test_name, DEPTH, run_len);
      end
      run_len = 0;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_modulation.sv
`default_nettype none

module tb_modulation;

  timeunit 1ns;
  timeprecision 100ps;

  import mod_pkg::*;

  localparam int WIDTH = 13;
  localparam int DEPTH = 16;
  localparam int MOD_SIZE = 256;
  localparam int CLK_PERIOD = 100;
  localparam int FIRST_OUT_CYCLES = 9;
  localparam int NUM_FRAMES = 14;
  localparam int LOAD_CYCLES = 2 * DEPTH + MOD_SIZE + 16;
  localparam int FRAME_TIMEOUT = DEPTH + 40;    // Cycles before a frame counts as stuck

  logic CLK = 1'b0;
  logic reset;
  logic frame_start;
  logic [MOD_ADDR_WIDTH-1:0] cycle_m;
  logic [MOD_ADDR_WIDTH-1:0] delay_m;
  logic tbl_we;
  logic [$clog2(DEPTH)-1:0] tbl_addr;
  logic [WIDTH-1:0] tbl_duty;
  logic [WIDTH-1:0] tbl_phase;
  logic mod_we;
  logic [MOD_ADDR_WIDTH-1:0] mod_waddr;
  logic [MOD_DATA_WIDTH-1:0] mod_wdata;
  logic dout_valid;
  logic [WIDTH-1:0] duty_out;
  logic [WIDTH-1:0] phase_out;
  logic busy;

  int chk_errors;
  int chk_checks;
  int chk_outs;
  integer seed = 54324;
  int duty_ref [DEPTH];
  int phase_ref [DEPTH];
  int sample_ref [MOD_SIZE];
  int ref_idx = 0;                               // Own copy of the modulation index
  int tb_errors = 0;
  int tb_checks = 0;
  int tests_done = 0;
  int errors_at_start = 0;
  string test_name = "none";

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  modulation_top #(.WIDTH(WIDTH), .DEPTH(DEPTH), .MOD_SIZE(MOD_SIZE)) u_dut (.*);

  tb_modulation_checks #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_chk (
    .CLK(CLK), .reset(reset), .frame_start(frame_start), .busy(busy),
    .dout_valid(dout_valid), .duty_out(duty_out), .phase_out(phase_out),
    .error_count(chk_errors), .check_count(chk_checks), .out_count(chk_outs)
  );

  function automatic int total_errors();
    return tb_errors + chk_errors;
  endfunction

  function automatic int wrapped_addr(input int idx, input int delay, input int cycle);
    int diff;
    diff = idx - delay;
    if (diff < 0) begin
      diff = diff + cycle + 1;
    end
    return diff;
  endfunction

  task automatic compare_value(input string what, input int expected, input int actual);
    tb_checks++;
    assert (expected == actual) else begin
      tb_errors++;
      $display("CHECK FAILED %s: %s expected %0d, actual %0d",
               test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    u_chk.set_test(name);
    errors_at_start = total_errors();
  endtask

  task automatic end_test();
    tests_done++;
    $display("test %s finished with %0d errors", test_name, total_errors() - errors_at_start);
  endtask

  task automatic write_entry(input int k, input int duty, input int phase);
    @(posedge CLK);
    #1;
    tbl_we = 1'b1;
    tbl_addr = $bits(tbl_addr)'(k);
    tbl_duty = WIDTH'(duty);
    tbl_phase = WIDTH'(phase);
    duty_ref[k] = duty;
    phase_ref[k] = phase;
  endtask

  task automatic write_sample(input int a, input int value);
    @(posedge CLK);
    #1;
    mod_we = 1'b1;
    mod_waddr = MOD_ADDR_WIDTH'(a);
    mod_wdata = MOD_DATA_WIDTH'(value);
    sample_ref[a] = value;
  endtask

  task automatic release_writes();
    @(posedge CLK);
    #1;
    tbl_we = 1'b0;
    mod_we = 1'b0;
  endtask

  task automatic load_table();
    for (int k = 0; k < DEPTH; k++) begin
      write_entry(k, $random(seed) & ((1 << WIDTH) - 1), $random(seed) & ((1 << WIDTH) - 1));
    end
    release_writes();
  endtask

  task automatic load_samples();
    for (int a = 0; a < MOD_SIZE; a++) begin
      write_sample(a, $random(seed) & 8'hff);
    end
    release_writes();
  endtask

  // One frame, with an optional second strobe extra_at cycles after the first
  task automatic run_frame(input int extra_at);
    int k;
    int addr;
    int cyc;
    int first_cyc;
    int nvalid;
    addr = wrapped_addr(ref_idx, delay_m, cycle_m);
    for (k = 0; k < DEPTH; k++) begin
      u_chk.push_expect(duty_ref[k], phase_ref[k], sample_ref[addr]);
    end
    @(posedge CLK);
    #1;
    frame_start = 1'b1;
    cyc = 0;
    first_cyc = -1;
    nvalid = 0;
    do begin
      @(posedge CLK);
      #1;
      cyc++;
      frame_start = (cyc == extra_at);
      if (dout_valid) begin
        nvalid++;
        if (first_cyc < 0) begin
          first_cyc = cyc;
        end
      end
    end while (busy && cyc < FRAME_TIMEOUT);
    if (busy) begin
      tb_errors++;
      $display("ERROR %s: busy stayed high past the frame timeout", test_name);
    end
    compare_value("cycles to first output", FIRST_OUT_CYCLES, first_cyc);
    compare_value("outputs in frame", DEPTH, nvalid);
    compare_value("dout_valid after busy fell", 0, int'(dout_valid));
    compare_value("entries left in scoreboard", 0, u_chk.pending_count());
    ref_idx = (ref_idx >= cycle_m) ? 0 : ref_idx + 1;
  endtask

  initial begin
    #((NUM_FRAMES * (DEPTH + 12) + LOAD_CYCLES + 200) * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    reset = 1'b1;
    frame_start = 1'b0;
    cycle_m = 16'd7;
    delay_m = 16'd0;
    tbl_we = 1'b0;
    tbl_addr = '0;
    tbl_duty = '0;
    tbl_phase = '0;
    mod_we = 1'b0;
    mod_waddr = '0;
    mod_wdata = '0;
    repeat (3) @(posedge CLK);
    #1;
    reset = 1'b0;

    begin_test("reset_state");
    compare_value("dout_valid after reset", 0, int'(dout_valid));
    compare_value("busy after reset", 0, int'(busy));
    load_table();
    load_samples();
    run_frame(0);                                // Index 0 reads address 0
    end_test();

    begin_test("scaling");
    write_entry(0, (1 << WIDTH) - 1, 0);         // Full scale duty
    write_entry(1, 0, (1 << WIDTH) - 1);
    write_entry(2, 1, 1);
    write_sample(2, 0);
    write_sample(3, 255);
    release_writes();
    repeat (3) run_frame(0);                     // Samples 1, 2 and 3
    end_test();

    begin_test("frame_timing");
    run_frame(0);
    end_test();

    begin_test("index_wrap");
    cycle_m = 16'd5;
    delay_m = 16'd3;
    repeat (7) run_frame(0);                     // cycle_m + 2 frames
    end_test();

    begin_test("busy_ignore");
    run_frame(5);
    run_frame(DEPTH + 8);                        // Strobe on the last busy cycle
    repeat (3) begin
      @(posedge CLK);
      #1;
      compare_value("busy after ignored strobe", 0, int'(busy));
    end
    end_test();

    $display("tests %0d, checks %0d, outputs %0d, errors %0d",
             tests_done, tb_checks + chk_checks, chk_outs, total_errors());
    if (total_errors() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/mod_pkg.sv
rtl/drive_table_gen.sv
rtl/mod_sample_mem.sv
rtl/modulation_multiplier.sv
rtl/modulation_top.sv
verification/tb_modulation_checks.sv
verification/tb_modulation.sv

// File: Bender.yml
package:
  name: modulation_stage

sources:
  - rtl/mod_pkg.sv
  - rtl/drive_table_gen.sv
  - rtl/mod_sample_mem.sv
  - rtl/modulation_multiplier.sv
  - rtl/modulation_top.sv
  - target: test
    files:
      - verification/tb_modulation_checks.sv
      - verification/tb_modulation.sv
